//--- source/gamePkg.sv
`default_nettype none

package gamePkg;

    localparam int SLOT_COUNT       = 6;
    localparam int DIGITS_PER_ENTRY = 12;   // Six pairs of tens and ones
    localparam int SWITCH_COUNT     = 10;

    typedef enum logic [2:0] {
        idle,
        guessRun,
        guessResult,
        storeRun,
        abortState
    } gameState;

    // Digits entered in the current run
    typedef logic [3:0] pairCount;

    typedef logic [7:0] secretValue;   // Tens in the upper nibble

    typedef struct packed {
        logic       valid;
        logic [3:0] digit;
    } keyEvent;

    typedef struct packed {
        logic center;   // Reset game
        logic top;      // Enter
        logic bottom;   // Abort
        logic left;     // Guess mode
        logic right;    // Store mode
    } buttonSet;

endpackage

`default_nettype wire

//--- source/displayPkg.sv
`default_nettype none

package displayPkg;

    localparam int SCAN_PERIOD = 100000;
    localparam int DIGIT_COUNT = 4;

    // Digits keep their own value as code
    typedef enum logic [4:0] {
        digit0, digit1, digit2, digit3, digit4,
        digit5, digit6, digit7, digit8, digit9,
        letterT, letterH, letterS, letterN, letterR,
        letterD, letterA, letterB, dash, blank
    } glyph;

    typedef struct packed {
        glyph slot3;
        glyph slot2;
        glyph slot1;
        glyph slot0;
    } displayFrame;

    typedef logic [6:0] segmentPattern;   // gfedcba, active low

    function automatic segmentPattern glyphSegments(glyph g);
        case (g)
            digit0:  return 7'b1000000;
            digit1:  return 7'b1111001;
            digit2:  return 7'b0100100;
            digit3:  return 7'b0110000;
            digit4:  return 7'b0011001;
            digit5:  return 7'b0010010;
            digit6:  return 7'b0000010;
            digit7:  return 7'b1111000;
            digit8:  return 7'b0000000;
            digit9:  return 7'b0010000;
            letterT: return 7'b0000111;
            letterH: return 7'b0001011;
            letterS: return 7'b0010010;   // Same as 5
            letterN: return 7'b0101011;
            letterR: return 7'b0101111;
            letterD: return 7'b0100001;
            letterA: return 7'b0001000;
            letterB: return 7'b0000011;
            dash:    return 7'b0111111;
            default: return 7'b1111111;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- source/secretStore.sv
`default_nettype none

module secretStore (
    input  wire                       clk,
    input  wire                       resetn,
    input  wire                       writeEnable,
    input  wire [2:0]                 slot,
    input  wire gamePkg::secretValue  writeValue,
    output gamePkg::secretValue       readValue
);

    gamePkg::secretValue secrets [gamePkg::SLOT_COUNT];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 0; i < gamePkg::SLOT_COUNT; i++) begin
                secrets[i] <= '0;
            end
        end else if (writeEnable && (slot < 3'(gamePkg::SLOT_COUNT))) begin
            secrets[slot] <= writeValue;
        end
    end

    // Out-of-range slots read as zero
    always_comb begin
        readValue = '0;
        for (int i = 0; i < gamePkg::SLOT_COUNT; i++) begin
            if (slot == 3'(i)) begin
                readValue = secrets[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/keyInput.sv
`default_nettype none

module keyInput (
    input  wire                               clk,
    input  wire                               resetn,
    input  wire [gamePkg::SWITCH_COUNT-1:0]   switches,
    input  wire [4:0]                         buttonsRaw,
    output gamePkg::keyEvent                  key,
    output gamePkg::buttonSet                 buttons
);

    logic [gamePkg::SWITCH_COUNT-1:0] switchMeta, switchSync, switchPrev;
    logic [4:0] buttonMeta, buttonSync, buttonPrev;
    logic [3:0] digitCode;
    logic oneHot;

    // Count set switches and keep the index of the last one
    always_comb begin
        int setBits;
        setBits = 0;
        digitCode = '0;
        for (int i = 0; i < gamePkg::SWITCH_COUNT; i++) begin
            if (switchSync[i]) begin
                setBits = setBits + 1;
                digitCode = 4'(i);
            end
        end
        oneHot = (setBits == 1);
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            switchMeta <= '0;
            switchSync <= '0;
            switchPrev <= '0;
            buttonMeta <= '0;
            buttonSync <= '0;
            buttonPrev <= '0;
            key        <= '0;
            buttons    <= '0;
        end else begin
            switchMeta <= switches;
            switchSync <= switchMeta;
            switchPrev <= switchSync;
            buttonMeta <= buttonsRaw;
            buttonSync <= buttonMeta;
            buttonPrev <= buttonSync;
            key.valid  <= oneHot && (switchPrev == '0);   // Only from all-off
            key.digit  <= digitCode;
            buttons    <= gamePkg::buttonSet'(buttonSync & ~buttonPrev);
        end
    end

endmodule

`default_nettype wire

//--- source/gameControl.sv
`default_nettype none

module gameControl (
    input  wire                      clk,
    input  wire                      resetn,
    input  wire gamePkg::keyEvent    key,
    input  wire gamePkg::buttonSet   buttons,
    output gamePkg::gameState        state,
    output gamePkg::pairCount        digitCount,
    output logic [3:0]               tensDigit,
    output logic [3:0]               onesDigit,
    output logic [2:0]               hits
);

    logic runState, countFull, keyTaken;
    logic writeEnable, pairMatch;
    logic [2:0] slot;
    gamePkg::secretValue pairValue, storedValue;

    assign runState  = (state == gamePkg::guessRun) || (state == gamePkg::storeRun);
    assign countFull = (digitCount == gamePkg::pairCount'(gamePkg::DIGITS_PER_ENTRY));

    // A digit counts only when no button acts in the same cycle
    assign keyTaken = runState && key.valid && !countFull && !buttons.bottom && !buttons.top;

    assign slot      = digitCount[3:1];
    assign pairValue = {tensDigit, key.digit};   // Second digit completes the pair

    assign writeEnable = keyTaken && digitCount[0] && (state == gamePkg::storeRun);
    assign pairMatch   = keyTaken && digitCount[0] && (state == gamePkg::guessRun)
                         && (storedValue == pairValue);

    secretStore store_i (
        .clk         (clk),
        .resetn      (resetn),
        .writeEnable (writeEnable),
        .slot        (slot),
        .writeValue  (pairValue),
        .readValue   (storedValue)
    );

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state      <= gamePkg::idle;
            digitCount <= '0;
            tensDigit  <= '0;
            onesDigit  <= '0;
            hits       <= '0;
        end else begin
            case (state)
                gamePkg::idle: begin
                    if (buttons.left || buttons.right) begin
                        if (buttons.left) begin
                            state <= gamePkg::guessRun;
                        end else begin
                            state <= gamePkg::storeRun;
                        end
                        digitCount <= '0;
                        tensDigit  <= '0;
                        onesDigit  <= '0;
                        hits       <= '0;
                    end
                end
                gamePkg::guessRun, gamePkg::storeRun: begin
                    if (buttons.bottom) begin
                        state <= gamePkg::abortState;
                    end else if (buttons.top) begin
                        if (!countFull) begin
                            state <= gamePkg::abortState;   // Short entry
                        end else if (state == gamePkg::guessRun) begin
                            state <= gamePkg::guessResult;
                        end else begin
                            state <= gamePkg::idle;
                        end
                    end else if (key.valid && countFull) begin
                        state <= gamePkg::abortState;       // Thirteenth digit
                    end else if (keyTaken) begin
                        digitCount <= digitCount + 1'b1;
                        if (digitCount[0]) begin
                            onesDigit <= key.digit;
                        end else begin
                            tensDigit <= key.digit;
                        end
                        if (pairMatch) begin
                            hits <= hits + 1'b1;
                        end
                    end
                end
                gamePkg::guessResult, gamePkg::abortState: begin
                    if (buttons.center) state <= gamePkg::idle;
                end
                default: state <= gamePkg::idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/frameComposer.sv
`default_nettype none

module frameComposer (
    input  wire gamePkg::gameState   state,
    input  wire gamePkg::pairCount   digitCount,
    input  wire [3:0]                tensDigit,
    input  wire [3:0]                onesDigit,
    input  wire [2:0]                hits,
    output displayPkg::displayFrame  frame
);

    logic [2:0] rank;
    displayPkg::glyph suffixHigh, suffixLow;
    displayPkg::glyph pairGlyph, tensGlyph, onesGlyph;

    assign rank = 3'd7 - hits;   // Six hits is first place

    assign pairGlyph = displayPkg::glyph'({2'b00, digitCount[3:1]});
    assign tensGlyph = displayPkg::glyph'({1'b0, tensDigit});
    assign onesGlyph = digitCount[0] ? displayPkg::blank : displayPkg::glyph'({1'b0, onesDigit});

    always_comb begin
        case (rank)
            3'd1: begin
                suffixHigh = displayPkg::letterS;
                suffixLow  = displayPkg::letterT;
            end
            3'd2: begin
                suffixHigh = displayPkg::letterN;
                suffixLow  = displayPkg::letterD;
            end
            3'd3: begin
                suffixHigh = displayPkg::letterR;
                suffixLow  = displayPkg::letterD;
            end
            default: begin
                suffixHigh = displayPkg::letterT;
                suffixLow  = displayPkg::letterH;
            end
        endcase
    end

    always_comb begin
        case (state)
            gamePkg::guessRun, gamePkg::storeRun:
                frame = '{pairGlyph, displayPkg::blank, tensGlyph, onesGlyph};
            gamePkg::guessResult:
                frame = '{displayPkg::blank, displayPkg::glyph'({2'b00, rank}),
                          suffixHigh, suffixLow};
            gamePkg::abortState:
                frame = '{displayPkg::letterA, displayPkg::letterB,
                          displayPkg::dash, displayPkg::dash};
            default:
                frame = '{displayPkg::dash, displayPkg::dash,
                          displayPkg::dash, displayPkg::dash};
        endcase
    end

endmodule

`default_nettype wire

//--- source/displayScanner.sv
`default_nettype none

module displayScanner #(
    parameter int scanPeriod = displayPkg::SCAN_PERIOD
) (
    input  wire                                 clk,
    input  wire                                 resetn,
    input  wire displayPkg::displayFrame        frame,
    output logic [displayPkg::DIGIT_COUNT-1:0]  ssSel,
    output displayPkg::segmentPattern           ssDisp
);

    logic [$clog2(scanPeriod + 1)-1:0] periodCount;
    logic [$clog2(displayPkg::DIGIT_COUNT)-1:0] digitIndex;
    logic periodEnd;
    displayPkg::glyph currentGlyph;

    assign periodEnd = (periodCount == ($bits(periodCount))'(scanPeriod - 1));

    // Slot shown at the next step
    always_comb begin
        case (digitIndex)
            2'd0:    currentGlyph = frame.slot0;
            2'd1:    currentGlyph = frame.slot1;
            2'd2:    currentGlyph = frame.slot2;
            default: currentGlyph = frame.slot3;
        endcase
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            periodCount <= '0;
            digitIndex  <= '0;
            ssSel       <= '1;   // All digits off
            ssDisp      <= '1;
        end else if (periodEnd) begin
            periodCount <= '0;
            digitIndex  <= digitIndex + 1'b1;
            ssSel       <= ~(($bits(ssSel))'(1) << digitIndex);
            ssDisp      <= displayPkg::glyphSegments(currentGlyph);
        end else begin
            periodCount <= periodCount + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/guessingGame.sv
`default_nettype none

module guessingGame #(
    parameter int scanPeriod = displayPkg::SCAN_PERIOD
) (
    input  wire                                 clk,
    input  wire                                 resetn,
    input  wire [gamePkg::SWITCH_COUNT-1:0]     switches,
    input  wire [4:0]                           buttonsRaw,   // Center, top, bottom, left, right
    output logic [displayPkg::DIGIT_COUNT-1:0]  ssSel,
    output displayPkg::segmentPattern           ssDisp
);

    gamePkg::keyEvent key;
    gamePkg::buttonSet buttons;
    gamePkg::gameState state;
    gamePkg::pairCount digitCount;
    logic [3:0] tensDigit, onesDigit;
    logic [2:0] hits;
    displayPkg::displayFrame frame;

    keyInput keyInput_i (
        .clk        (clk),
        .resetn     (resetn),
        .switches   (switches),
        .buttonsRaw (buttonsRaw),
        .key        (key),
        .buttons    (buttons)
    );

    gameControl gameControl_i (
        .clk        (clk),
        .resetn     (resetn),
        .key        (key),
        .buttons    (buttons),
        .state      (state),
        .digitCount (digitCount),
        .tensDigit  (tensDigit),
        .onesDigit  (onesDigit),
        .hits       (hits)
    );

    frameComposer frameComposer_i (
        .state      (state),
        .digitCount (digitCount),
        .tensDigit  (tensDigit),
        .onesDigit  (onesDigit),
        .hits       (hits),
        .frame      (frame)
    );

    displayScanner #(
        .scanPeriod (scanPeriod)
    ) displayScanner_i (
        .clk        (clk),
        .resetn     (resetn),
        .frame      (frame),
        .ssSel      (ssSel),
        .ssDisp     (ssDisp)
    );

endmodule

`default_nettype wire

//--- testbench/tbSupport.svh
`ifndef TB_SUPPORT_SVH
`define TB_SUPPORT_SVH

logic [31:0] lfsrState = 32'h617e855e;

// Galois LFSR, one output bit per step
function automatic logic takeRandomBit();
    logic outBit;
    outBit = lfsrState[0];
    lfsrState = (lfsrState >> 1) ^ (outBit ? 32'h80200003 : 32'h0);
    return outBit;
endfunction

function automatic int randomDigit();
    int value;
    value = 0;
    for (int i = 0; i < 4; i++) begin
        value = value * 2 + int'(takeRandomBit());
    end
    return value % 10;
endfunction

// Expected display for a game situation
function automatic displayPkg::displayFrame referenceFrame(
    input gamePkg::gameState st, input int count, input int tens, input int ones,
    input int hitCount);
    displayPkg::displayFrame f;
    int rank;
    rank = 7 - hitCount;
    f = '{displayPkg::dash, displayPkg::dash, displayPkg::dash, displayPkg::dash};
    case (st)
        gamePkg::guessRun, gamePkg::storeRun: begin
            f.slot3 = displayPkg::glyph'(5'(count / 2));
            f.slot2 = displayPkg::blank;
            f.slot1 = displayPkg::glyph'(5'(tens));
            f.slot0 = (count % 2 == 1) ? displayPkg::blank : displayPkg::glyph'(5'(ones));
        end
        gamePkg::guessResult: begin
            f.slot3 = displayPkg::blank;
            f.slot2 = displayPkg::glyph'(5'(rank));
            f.slot1 = (rank == 1) ? displayPkg::letterS : (rank == 2) ? displayPkg::letterN
                    : (rank == 3) ? displayPkg::letterR : displayPkg::letterT;
            f.slot0 = (rank == 1) ? displayPkg::letterT
                    : (rank < 4) ? displayPkg::letterD : displayPkg::letterH;
        end
        gamePkg::abortState: begin
            f.slot3 = displayPkg::letterA;
            f.slot2 = displayPkg::letterB;
        end
        default: ;
    endcase
    return f;
endfunction

// First glyph code with this pattern, 5'h1f when none matches
function automatic logic [4:0] decodeSegments(input displayPkg::segmentPattern s);
    for (int g = 0; g < 20; g++) begin
        if (displayPkg::glyphSegments(displayPkg::glyph'(5'(g))) == s) begin
            return 5'(g);
        end
    end
    return 5'h1f;
endfunction

task automatic checkValue(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
    if (actual !== expected) begin
        $display("** Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
        stopWithFailure();
    end
endtask

`endif

//--- testbench/tbGuessingGame.sv
`default_nettype none

module tbGuessingGame;

    localparam logic [4:0] CENTER = 5'b10000;   // Bit order of gamePkg::buttonSet
    localparam logic [4:0] TOP    = 5'b01000;
    localparam logic [4:0] BOTTOM = 5'b00100;
    localparam logic [4:0] LEFT   = 5'b00010;
    localparam logic [4:0] RIGHT  = 5'b00001;
    // About 110 presses of 12 cycles and 20 frame reads of up to 20 cycles
    localparam int WATCHDOG_CYCLES = 110 * 12 + 20 * 20 + 200;

    logic clk = 1'b0;
    logic resetn = 1'b0;
    logic [gamePkg::SWITCH_COUNT-1:0] switches;
    logic [4:0] buttonsRaw;
    logic [displayPkg::DIGIT_COUNT-1:0] ssSel;
    displayPkg::segmentPattern ssDisp;
    displayPkg::displayFrame expectedFrame;
    logic frameRequest = 1'b0;
    logic frameDone = 1'b0;

    gamePkg::gameState modelState;   // Game model
    int modelCount, modelTens, modelOnes, modelHits;
    logic [7:0] modelSecrets [gamePkg::SLOT_COUNT];
    logic [7:0] savedSecrets [gamePkg::SLOT_COUNT];

    `include "tbSupport.svh"

    guessingGame #(.scanPeriod(4)) dut_i (
        .clk        (clk),
        .resetn     (resetn),
        .switches   (switches),
        .buttonsRaw (buttonsRaw),
        .ssSel      (ssSel),
        .ssDisp     (ssDisp)
    );

    always #20 clk = ~clk;

    task automatic stopWithFailure();
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    // Starts and ends 5 time units after a rising edge
    task automatic pressInput(input logic [9:0] switchVec, input logic [4:0] buttonVec);
        switches = switchVec;
        buttonsRaw = buttonVec;
        repeat (6) @(posedge clk);
        #5;
        switches = '0;
        buttonsRaw = '0;
        repeat (6) @(posedge clk);
        #5;
    endtask

    task automatic resetDut();
        resetn = 1'b0;
        modelState = gamePkg::idle;
        modelCount = 0;
        modelTens = 0;
        modelOnes = 0;
        modelHits = 0;
        foreach (modelSecrets[i]) modelSecrets[i] = '0;
        repeat (2) @(posedge clk);
        #5 resetn = 1'b1;
        @(posedge clk);
        #5;
    endtask

    task automatic enterDigit(input int d);
        logic [7:0] pair;
        pressInput(10'b1 << d, 5'b0);
        pair = {4'(modelTens), 4'(d)};
        if (modelState == gamePkg::guessRun || modelState == gamePkg::storeRun) begin
            if (modelCount == gamePkg::DIGITS_PER_ENTRY) begin
                modelState = gamePkg::abortState;
            end else begin
                if (modelCount % 2 == 0) begin
                    modelTens = d;
                end else begin
                    modelOnes = d;
                    if (modelState == gamePkg::storeRun) begin
                        modelSecrets[modelCount / 2] = pair;
                    end else if (modelSecrets[modelCount / 2] == pair) begin
                        modelHits++;
                    end
                end
                modelCount++;
            end
        end
    endtask

    task automatic enterRandomDigits(input int n);
        for (int i = 0; i < n; i++) begin
            enterDigit(randomDigit());
        end
    endtask

    task automatic pressButton(input logic [4:0] b);
        pressInput('0, b);
        case (modelState)
            gamePkg::idle: begin
                if (b == LEFT || b == RIGHT) begin
                    modelState = (b == LEFT) ? gamePkg::guessRun : gamePkg::storeRun;
                    modelCount = 0;
                    modelTens = 0;
                    modelOnes = 0;
                    modelHits = 0;
                end
            end
            gamePkg::guessRun, gamePkg::storeRun: begin
                if (b == BOTTOM || (b == TOP && modelCount != gamePkg::DIGITS_PER_ENTRY)) begin
                    modelState = gamePkg::abortState;
                end else if (b == TOP) begin
                    modelState = (modelState == gamePkg::guessRun) ? gamePkg::guessResult
                                                                   : gamePkg::idle;
                end
            end
            default: if (b == CENTER) modelState = gamePkg::idle;
        endcase
    endtask

    // Replays savedSecrets, an LFSR bit may spoil the ones digit
    task automatic guessPairs(input bit missSome);
        int ones;
        for (int s = 0; s < gamePkg::SLOT_COUNT; s++) begin
            ones = int'(savedSecrets[s][3:0]);
            if (missSome && !takeRandomBit()) ones = (ones + 1) % 10;
            enterDigit(int'(savedSecrets[s][7:4]));
            enterDigit(ones);
        end
    endtask

    task automatic checkFrame();
        expectedFrame = referenceFrame(modelState, modelCount, modelTens, modelOnes, modelHits);
        frameRequest = 1'b1;
        wait (frameDone);
        frameRequest = 1'b0;
        wait (!frameDone);
        @(posedge clk);
        #5;
    endtask

    // One full scan, four new selects, sampled on the falling edge
    always begin : compareFrames
        logic [3:0] prevSel, seenMask;
        logic [1:0] idx;
        logic [4:0] seen [displayPkg::DIGIT_COUNT];
        wait (frameRequest);
        @(negedge clk);
        prevSel = ssSel;
        seenMask = '0;
        idx = '0;
        while (seenMask != 4'hf) begin
            @(negedge clk);
            if (ssSel != prevSel) begin
                checkValue("ssSel active lines", 32'($countones(~ssSel)), 32'd1);
                for (int i = 0; i < displayPkg::DIGIT_COUNT; i++) begin
                    if (!ssSel[i]) idx = 2'(i);
                end
                seen[idx] = decodeSegments(ssDisp);
                seenMask[idx] = 1'b1;
            end
            prevSel = ssSel;
        end
        for (int i = 0; i < displayPkg::DIGIT_COUNT; i++) begin
            checkValue($sformatf("ssDisp glyph of slot %0d", i), 32'(seen[i]),
                32'(decodeSegments(displayPkg::glyphSegments(
                    displayPkg::glyph'(expectedFrame[5*i +: 5])))));
        end
        frameDone = 1'b1;
        wait (!frameRequest);
        frameDone = 1'b0;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the test did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        stopWithFailure();
    end

    initial begin : stimulus
        switches = '0;
        buttonsRaw = '0;
        resetDut();
        checkValue("ssSel", 32'(ssSel), 32'hf);   // Still inside the first scan period
        checkValue("ssDisp", 32'(ssDisp), 32'h7f);
        checkFrame();

        pressButton(RIGHT);
        enterRandomDigits(12);
        pressButton(TOP);
        checkFrame();
        savedSecrets = modelSecrets;
        pressButton(LEFT);
        guessPairs(1'b0);
        pressButton(TOP);
        checkFrame();
        pressButton(CENTER);
        checkFrame();

        // Partial pair and a two-switch vector, then abort
        pressButton(LEFT);
        checkFrame();
        enterDigit(randomDigit());
        checkFrame();
        pressInput(10'b0010000100, 5'b0);
        checkFrame();
        enterDigit(randomDigit());
        checkFrame();
        pressButton(BOTTOM);
        checkFrame();
        pressButton(CENTER);

        pressButton(LEFT);
        guessPairs(1'b1);
        pressButton(TOP);
        checkFrame();
        pressButton(CENTER);
        checkFrame();

        pressButton(LEFT);
        enterRandomDigits(10);
        pressButton(TOP);
        checkFrame();
        pressButton(CENTER);
        checkFrame();
        pressButton(RIGHT);
        enterRandomDigits(13);
        checkFrame();
        pressButton(CENTER);
        checkFrame();

        // Secrets are lost on reset
        pressButton(RIGHT);
        enterRandomDigits(12);
        pressButton(TOP);
        savedSecrets = modelSecrets;
        resetDut();
        checkFrame();
        pressButton(LEFT);
        guessPairs(1'b0);
        pressButton(TOP);
        checkFrame();
        pressButton(CENTER);
        checkFrame();

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+testbench
source/gamePkg.sv
source/displayPkg.sv
source/secretStore.sv
source/keyInput.sv
source/gameControl.sv
source/frameComposer.sv
source/displayScanner.sv
source/guessingGame.sv
testbench/tbGuessingGame.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbGuessingGame
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, whatever the simulator exit status was
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
